// File: hw/uartPeripheral.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uartPeripheral
	import uartPkg::*;
(
	input  logic CLK,
	input  logic RESET,
	input  logic i_rd,
	input  logic i_wr,
	input  logic [`UART_ADDR_WIDTH-1:0] i_addr,
	input  logic [`UART_BUS_WIDTH-1:0] i_din,
	output logic [`UART_BUS_WIDTH-1:0] o_dout,
	output logic o_interrupt,
	input  logic i_rxd,
	output logic o_txd
);

	// Internal links between registers and serial logic.
	uartTxIf txBus();
	uartRxIf rxBus();

	// Bus side, register map and flags.
	uartRegisterBlock regBlock (
		.CLK        (CLK),
		.RESET      (RESET),
		.i_rd       (i_rd),
		.i_wr       (i_wr),
		.i_addr     (uartRegAddr_e'(i_addr)),
		.i_din      (i_din),
		.o_dout     (o_dout),
		.o_interrupt(o_interrupt),
		.txBus      (txBus.ctrl),
		.rxBus      (rxBus.ctrl)
	);

	// Serial in.
	uartReceiver receiver (
		.CLK  (CLK),
		.RESET(RESET),
		.i_rxd(i_rxd),
		.rxBus(rxBus.phy)
	);

	// Serial out.
	uartTransmitter transmitter (
		.CLK  (CLK),
		.RESET(RESET),
		.o_txd(o_txd),
		.txBus(txBus.phy)
	);

endmodule

// File: hw/uartPkg.sv
`include "uart_cfg.svh"

package uartPkg;

	// ********************
	// Register map.
	// ********************
	typedef enum logic [`UART_ADDR_WIDTH-1:0] {
		addrStatus = 2'd0,
		addrData   = 2'd1,
		addrRxDiv  = 2'd2,
		addrTxDiv  = 2'd3
	} uartRegAddr_e;

	// Receiver FSM.
	typedef enum logic [1:0] {
		rxIdle,
		rxStartBit,
		rxDataBits,
		rxStopBit
	} uartRxState_e;

	// Transmitter FSM.
	typedef enum logic [1:0] {
		txIdle,
		txStartBit,
		txDataBits,
		txStopBit
	} uartTxState_e;

endpackage

// File: hw/uartReceiver.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uartReceiver
	import uartPkg::*;
(
	input  logic CLK,
	input  logic RESET,
	input  logic i_rxd,
	uartRxIf.phy rxBus
);

	logic rxMeta;
	logic rxSync;
	uartRxState_e state;
	logic [`UART_BUS_WIDTH-1:0] clkCnt;
	logic [$clog2(`UART_BYTE_WIDTH)-1:0] bitIdx;
	logic [`UART_BYTE_WIDTH-1:0] shiftReg;
	logic [`UART_BYTE_WIDTH-1:0] rxByteReg;
	logic rxValidReg;
	logic bitTick;
	logic halfTick;

	// Full bit time and half bit time reached.
	assign bitTick  = (clkCnt == rxBus.rxDiv - 1'b1);
	assign halfTick = (clkCnt == (rxBus.rxDiv >> 1));

	assign rxBus.rxValid = rxValidReg;
	assign rxBus.rxByte  = rxByteReg;

	// ********************
	// Two-flop synchronizer, line idles high.
	// ********************
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
		end else begin
			rxMeta <= i_rxd;
			rxSync <= rxMeta;
		end
	end

	// ********************
	// Frame FSM.
	// ********************
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			state      <= rxIdle;
			clkCnt     <= '0;
			bitIdx     <= '0;
			rxByteReg  <= '0;
			rxValidReg <= 1'b0;
		end else begin
			// Strobe lasts one cycle.
			rxValidReg <= 1'b0;
			clkCnt     <= clkCnt + 1'b1;
			case (state)
				rxIdle: begin
					clkCnt <= '0;
					// Falling edge marks a start bit.
					if (!rxSync) begin
						state <= rxStartBit;
					end
				end
				rxStartBit: begin
					// Mid start bit, glitch if line is high again.
					if (halfTick) begin
						clkCnt <= '0;
						bitIdx <= '0;
						state  <= rxSync ? rxIdle : rxDataBits;
					end
				end
				rxDataBits: begin
					if (bitTick) begin
						clkCnt <= '0;
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == `UART_BYTE_WIDTH - 1) begin
							state <= rxStopBit;
						end
					end
				end
				rxStopBit: begin
					// Middle of the stop bit, hand the byte over.
					if (bitTick) begin
						clkCnt     <= '0;
						rxByteReg  <= shiftReg;
						rxValidReg <= 1'b1;
						state      <= rxIdle;
					end
				end
				default: state <= rxIdle;
			endcase
		end
	end

	// Data bits arrive LSB first.
	always_ff @(posedge CLK) begin
		if (state == rxDataBits && bitTick) begin
			shiftReg <= {rxSync, shiftReg[`UART_BYTE_WIDTH-1:1]};
		end
	end

endmodule

// File: hw/uartRegisterBlock.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uartRegisterBlock
	import uartPkg::*;
(
	input  logic CLK,
	input  logic RESET,
	input  logic i_rd,
	input  logic i_wr,
	input  uartRegAddr_e i_addr,
	input  logic [`UART_BUS_WIDTH-1:0] i_din,
	output logic [`UART_BUS_WIDTH-1:0] o_dout,
	output logic o_interrupt,
	uartTxIf.ctrl txBus,
	uartRxIf.ctrl rxBus
);

	logic [`UART_BUS_WIDTH-1:0] rxDivReg;
	logic [`UART_BUS_WIDTH-1:0] txDivReg;
	logic [`UART_BYTE_WIDTH-1:0] txByteReg;
	logic txStartReg;
	logic davFlag;
	logic txaFlag;
	logic txdFlag;
	logic txiFlag;
	logic [`UART_BUS_WIDTH-1:0] statusWord;
	logic [`UART_BUS_WIDTH-1:0] rxWord;

	assign txBus.txStart = txStartReg;
	assign txBus.txByte  = txByteReg;
	assign txBus.txDiv   = txDivReg;
	assign rxBus.rxDiv   = rxDivReg;

	// Received byte widened to the bus.
	assign rxWord = {{(`UART_BUS_WIDTH-`UART_BYTE_WIDTH){1'b0}}, rxBus.rxByte};

	// ********************
	// Status word.
	// ********************
	always_comb begin
		statusWord = '0;
		statusWord[`UART_STAT_DAV] = davFlag;
		statusWord[`UART_STAT_TXA] = txaFlag;
		statusWord[`UART_STAT_TXD] = txdFlag;
		statusWord[`UART_STAT_TXI] = txiFlag;
	end

	// Level interrupt for RX data or TX complete.
	assign o_interrupt = davFlag | txiFlag;

	// ********************
	// Flags, dividers and bus decode.
	// ********************
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			rxDivReg   <= `UART_DEFAULT_DIV;
			txDivReg   <= `UART_DEFAULT_DIV;
			txStartReg <= 1'b0;
			davFlag    <= 1'b0;
			txaFlag    <= 1'b0;
			txdFlag    <= 1'b1;
			txiFlag    <= 1'b0;
			o_dout     <= '0;
		end else begin
			// Latch events from the serial side.
			txaFlag <= txBus.txActive;
			if (rxBus.rxValid) begin
				davFlag <= 1'b1;
			end
			if (txBus.txDone) begin
				txdFlag <= 1'b1;
				txiFlag <= 1'b1;
			end
			// Transmitter takes the request on this edge.
			if (txStartReg && !txBus.txActive) begin
				txStartReg <= 1'b0;
			end

			// Read data shows up one cycle later or reads zero.
			o_dout <= '0;
			if (i_rd) begin
				case (i_addr)
					addrStatus: o_dout <= statusWord;
					addrData: begin
						// Clear on read.
						o_dout  <= rxWord;
						davFlag <= 1'b0;
					end
					addrRxDiv: o_dout <= rxDivReg;
					addrTxDiv: o_dout <= txDivReg;
					default: o_dout <= '0;
				endcase
			end

			// Bus writes win over same-cycle events.
			if (i_wr) begin
				case (i_addr)
					// Any value clears TXI.
					addrStatus: txiFlag <= 1'b0;
					addrData: begin
						txStartReg <= 1'b1;
						txdFlag    <= 1'b0;
						txiFlag    <= 1'b0;
					end
					addrRxDiv: rxDivReg <= i_din;
					addrTxDiv: txDivReg <= i_din;
				endcase
			end
		end
	end

	// Outgoing byte held for the transmitter.
	always_ff @(posedge CLK) begin
		if (i_wr && i_addr == addrData) begin
			txByteReg <= i_din[`UART_BYTE_WIDTH-1:0];
		end
	end

endmodule

// File: hw/uartRxIf.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

interface uartRxIf;

	// Received character and its one-cycle strobe.
	logic rxValid;
	logic [`UART_BYTE_WIDTH-1:0] rxByte;

	// Clocks per bit, from the register block.
	logic [`UART_BUS_WIDTH-1:0] rxDiv;

	modport ctrl (input rxValid, input rxByte, output rxDiv);

	modport phy (output rxValid, output rxByte, input rxDiv);

endinterface

// File: hw/uartTransmitter.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uartTransmitter
	import uartPkg::*;
(
	input  logic CLK,
	input  logic RESET,
	output logic o_txd,
	uartTxIf.phy txBus
);

	uartTxState_e state;
	logic [`UART_BUS_WIDTH-1:0] clkCnt;
	logic [$clog2(`UART_BYTE_WIDTH)-1:0] bitIdx;
	logic [$clog2(`UART_BYTE_WIDTH)-1:0] nextIdx;
	logic [`UART_BYTE_WIDTH-1:0] dataReg;
	logic txdReg;
	logic activeReg;
	logic doneReg;
	logic bitTick;
	logic accept;

	// End of the current bit.
	assign bitTick = (clkCnt == txBus.txDiv - 1'b1);
	assign nextIdx = bitIdx + 1'b1;
	// New frame only taken while idle.
	assign accept  = (state == txIdle) && txBus.txStart;

	assign o_txd          = txdReg;
	assign txBus.txActive = activeReg;
	assign txBus.txDone   = doneReg;

	// ********************
	// Frame FSM.
	// ********************
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			state     <= txIdle;
			clkCnt    <= '0;
			bitIdx    <= '0;
			txdReg    <= 1'b1;
			activeReg <= 1'b0;
			doneReg   <= 1'b0;
		end else begin
			doneReg <= 1'b0;
			clkCnt  <= clkCnt + 1'b1;
			case (state)
				txIdle: begin
					clkCnt <= '0;
					// Drop to the start bit.
					if (accept) begin
						txdReg    <= 1'b0;
						activeReg <= 1'b1;
						state     <= txStartBit;
					end
				end
				txStartBit: begin
					if (bitTick) begin
						clkCnt <= '0;
						bitIdx <= '0;
						txdReg <= dataReg[0];
						state  <= txDataBits;
					end
				end
				txDataBits: begin
					if (bitTick) begin
						clkCnt <= '0;
						if (bitIdx == `UART_BYTE_WIDTH - 1) begin
							// Last data bit done, stop bit is high.
							txdReg <= 1'b1;
							state  <= txStopBit;
						end else begin
							bitIdx <= nextIdx;
							txdReg <= dataReg[nextIdx];
						end
					end
				end
				txStopBit: begin
					// Frame over, one-cycle done strobe.
					if (bitTick) begin
						clkCnt    <= '0;
						activeReg <= 1'b0;
						doneReg   <= 1'b1;
						state     <= txIdle;
					end
				end
				default: state <= txIdle;
			endcase
		end
	end

	// Byte captured when the frame is accepted.
	always_ff @(posedge CLK) begin
		if (accept) begin
			dataReg <= txBus.txByte;
		end
	end

endmodule

// File: hw/uartTxIf.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

interface uartTxIf;

	// Request level and payload, from the register block.
	logic txStart;
	logic [`UART_BYTE_WIDTH-1:0] txByte;
	logic [`UART_BUS_WIDTH-1:0] txDiv;

	// Frame status, from the transmitter.
	logic txActive;
	logic txDone;

	// Register block side.
	modport ctrl (output txStart, output txByte, output txDiv,
		input txActive, input txDone);

	// Serial side.
	modport phy (input txStart, input txByte, input txDiv,
		output txActive, output txDone);

endinterface

// File: include/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// ********************
// Bus and character sizes.
// ********************
`define UART_BUS_WIDTH   16
`define UART_BYTE_WIDTH  8
`define UART_ADDR_WIDTH  2

// Divider after reset, 12 MHz / 115200 baud.
`define UART_DEFAULT_DIV 104

// ********************
// Status register bit positions.
// ********************
`define UART_STAT_DAV    0
`define UART_STAT_TXA    1
`define UART_STAT_TXD    2
`define UART_STAT_TXI    3

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the UART testbench with Verilator, from the project root.

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tbUartPeripheral \
	-f uartPeripheral.f -o simUart
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/simUart > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
	exit 1
fi
exit 0

// File: testbench/tbUartPeripheral.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module tbUartPeripheral
	import uartPkg::*;
();

	// One frame at divider 8, ten bits.
	localparam int FRAME_CYCLES = 10 * 8;
	localparam int TOKEN_W = 8 * 24;

	logic CLK;
	logic RESET;
	logic i_rd;
	logic i_wr;
	logic [`UART_ADDR_WIDTH-1:0] i_addr;
	logic [`UART_BUS_WIDTH-1:0] i_din;
	logic [`UART_BUS_WIDTH-1:0] o_dout;
	logic o_interrupt;
	logic i_rxd;
	logic o_txd;

	int errors = 0;
	int timeouts = 0;
	int cycles = 0;
	int cycleLimit = 1000000;
	int seed = 80;
	int rxBitCycles = `UART_DEFAULT_DIV;
	int txBitCycles = `UART_DEFAULT_DIV;
	logic [TOKEN_W-1:0] caseName;

	// Bytes seen on o_txd, oldest first.
	logic [7:0] txFrames[$];

	// Parsed cases.
	logic [7:0] opQ[$];
	logic [TOKEN_W-1:0] nameQ[$];
	logic [15:0] argAQ[$];
	logic [15:0] argBQ[$];

	uartPeripheral UUT (
		.CLK        (CLK),
		.RESET      (RESET),
		.i_rd       (i_rd),
		.i_wr       (i_wr),
		.i_addr     (i_addr),
		.i_din      (i_din),
		.o_dout     (o_dout),
		.o_interrupt(o_interrupt),
		.i_rxd      (i_rxd),
		.o_txd      (o_txd)
	);

	// ********************
	// Clock and watchdog.
	// ********************
	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout: simulation did not finish");
			timeouts = timeouts + 1;
			$display("errors=%0d timeouts=%0d", errors, timeouts);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic checkValue(input logic [TOKEN_W-1:0] name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %0s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// ********************
	// Bus tasks, entered 1 ns after an edge.
	// ********************
	task automatic busWrite(input logic [1:0] addr, input logic [15:0] data);
		i_addr = addr;
		i_din  = data;
		i_wr   = 1'b1;
		@(posedge CLK);
		#1;
		i_wr = 1'b0;
	endtask

	task automatic busRead(input logic [TOKEN_W-1:0] name, input logic [1:0] addr,
		input logic [15:0] expected);
		logic [15:0] got;
		i_addr = addr;
		i_rd   = 1'b1;
		@(posedge CLK);
		#1;
		i_rd = 1'b0;
		got  = o_dout;
		checkValue(name, expected, got);
		// Edge without a read, bus goes back to zero.
		@(posedge CLK);
		#1;
		checkValue(name, 16'h0000, o_dout);
	endtask

	// ********************
	// Serial side.
	// ********************
	// Start bit, LSB first, stop bit.
	task automatic sendSerial(input logic [7:0] value);
		logic [9:0] frame;
		int i;
		frame = {1'b1, value, 1'b0};
		for (i = 0; i < 10; i++) begin
			i_rxd = frame[i];
			repeat (rxBitCycles) @(posedge CLK);
			#1;
		end
	endtask

	// Samples each bit near its middle.
	task automatic captureFrame();
		logic [7:0] data;
		int i;
		@(negedge o_txd);
		repeat (txBitCycles / 2) @(negedge CLK);
		if (o_txd !== 1'b0) begin
			$display("start bit on o_txd ended before its middle");
			errors++;
		end else begin
			for (i = 0; i < 8; i++) begin
				repeat (txBitCycles) @(negedge CLK);
				data[i] = o_txd;
			end
			repeat (txBitCycles) @(negedge CLK);
			checkValue(caseName, 16'h0001, {15'h0000, o_txd});
			txFrames.push_back(data);
		end
	endtask

	task automatic expectFrame(input logic [TOKEN_W-1:0] name, input logic [7:0] expected);
		while (txFrames.size() == 0) begin
			@(posedge CLK);
			#1;
		end
		checkValue(name, {8'h00, expected}, {8'h00, txFrames.pop_front()});
	endtask

	task automatic waitInterrupt();
		while (o_interrupt !== 1'b1) begin
			@(posedge CLK);
			#1;
		end
	endtask

	// Random byte in on RXD, read back, then out on TXD.
	task automatic loopback(input logic [TOKEN_W-1:0] name);
		logic [7:0] value;
		value = $random(seed);
		sendSerial(value);
		waitInterrupt();
		busRead(name, addrData, {8'h00, value});
		busWrite(addrData, {8'h00, value});
		expectFrame(name, value);
		waitInterrupt();
		busWrite(addrStatus, 16'h0000);
	endtask

	// Monitor runs for the whole test.
	initial begin
		@(negedge RESET);
		forever captureFrame();
	end

	// ********************
	// Main sequence.
	// ********************
	initial begin
		int fd;
		int code;
		int n;
		logic [7:0] op;
		logic [TOKEN_W-1:0] name;
		logic [15:0] argA;
		logic [15:0] argB;
		logic [8*128-1:0] rest;
		RESET  = 1'b1;
		i_rd   = 1'b0;
		i_wr   = 1'b0;
		i_addr = '0;
		i_din  = '0;
		i_rxd  = 1'b1;
		caseName = "reset";

		fd = $fopen("testbench/uart_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/uart_cases.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", op);
				if (code != 1) begin
					break;
				end
				// Comment lines are skipped whole.
				if (op == "#") begin
					code = $fgets(rest, fd);
				end else begin
					code = $fscanf(fd, "%s %h %h", name, argA, argB);
					opQ.push_back(op);
					nameQ.push_back(name);
					argAQ.push_back(argA);
					argBQ.push_back(argB);
				end
			end
			$fclose(fd);
		end
		// Up to 12 frames per case, plus reset and setup.
		cycleLimit = opQ.size() * 12 * FRAME_CYCLES + 2000;

		repeat (3) @(posedge CLK);
		#1;
		RESET = 1'b0;

		for (n = 0; n < opQ.size(); n++) begin
			caseName = nameQ[n];
			argA = argAQ[n];
			argB = argBQ[n];
			case (opQ[n])
				"W": begin
					busWrite(argA[1:0], argB);
					// Keep the serial tasks at the DUT bit rate.
					if (uartRegAddr_e'(argA[1:0]) == addrRxDiv) begin
						rxBitCycles = argB;
					end
					if (uartRegAddr_e'(argA[1:0]) == addrTxDiv) begin
						txBitCycles = argB;
					end
				end
				"R": busRead(caseName, argA[1:0], argB);
				"S": sendSerial(argA[7:0]);
				"X": expectFrame(caseName, argA[7:0]);
				"I": waitInterrupt();
				"P": checkValue(caseName, argA, {14'h0000, o_txd, o_interrupt});
				"D": begin
					repeat (argA) begin
						@(posedge CLK);
						#1;
					end
				end
				"L": loopback(caseName);
				default: begin
					$display("unknown operation %0s in cases file", opQ[n]);
					errors++;
				end
			endcase
		end

		$display("errors=%0d timeouts=%0d", errors, timeouts);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/uart_cases.txt
# op name a b, with a and b in hex and 0 where unused
# W write a=addr b=data, R read a=addr b=expected, S send a on RXD, X expect a on TXD
# I wait for interrupt, P pins a={txd,irq}, D idle a cycles, L random loopback
R rstStatus 0 4
R rstRxDiv 2 68
R rstTxDiv 3 68
P rstPins 2 0
W setRxDiv 2 1234
R rdRxDiv 2 1234
W setTxDiv 3 abcd
R rdTxDiv 3 abcd
W fastRxDiv 2 8
W fastTxDiv 3 8
R rdFastRx 2 8
R rdFastTx 3 8
W txWrite 1 1a5
D txWait 4 0
R txActive 0 2
X txFrame a5 0
I txIrqWait 0 0
R txDone 0 c
P txIrqPins 3 0
W txIrqClear 0 0
R txCleared 0 4
P txIdlePins 2 0
S rxSend 5a 0
I rxIrqWait 0 0
R rxStatus 0 5
P rxIrqPins 3 0
R rxData 1 5a
R rxCleared 0 4
P rxIdlePins 2 0
W b2bWrite1 1 3c
W b2bWrite2 1 c3
X b2bFrame1 3c 0
X b2bFrame2 c3 0
D b2bTail 8 0
I b2bIrqWait 0 0
W b2bIrqClear 0 0
S b2bSend1 11 0
S b2bSend2 22 0
I b2bRxIrq 0 0
R b2bRxData 1 22
R b2bStatus 0 4
L loop1 0 0
L loop2 0 0
L loop3 0 0
R endStatus 0 4
P endPins 2 0

// File: uartPeripheral.f
+incdir+include
hw/uartPkg.sv
hw/uartTxIf.sv
hw/uartRxIf.sv
hw/uartReceiver.sv
hw/uartTransmitter.sv
hw/uartRegisterBlock.sv
hw/uartPeripheral.sv
testbench/tbUartPeripheral.sv
